// File: hdl/rv_pkg.sv
// shared types and encodings for the rv64 core; imported by the RTL modules and the testbench
`default_nettype none

package rv_pkg;

  typedef logic [63:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] instr_t;
  typedef logic [63:0] addr_t;
  typedef logic [6:0]  opcode_t;

  // major opcodes of the supported subset
  localparam opcode_t OP_IMM = 7'b0010011;
  localparam opcode_t OP     = 7'b0110011;
  localparam opcode_t LUI    = 7'b0110111;
  localparam opcode_t LOAD   = 7'b0000011;
  localparam opcode_t STORE  = 7'b0100011;
  localparam opcode_t BRANCH = 7'b1100011;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B,
    ALU_EQ
  } alu_op_t;

  // one instruction walks fetch, execute, optional mem, writeback
  typedef enum logic [2:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MEM,
    ST_WRITEBACK,
    ST_HALTED
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/regfile.sv
// integer register file with two combinational read ports and one clocked write port
`default_nettype none

module regfile
  import rv_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  wire reg_idx_t i_rs1,
  input  wire reg_idx_t i_rs2,
  input  wire reg_idx_t i_rd,
  input  wire           i_rd_wen,
  input  wire word_t    i_rd_data,
  output word_t         o_rs1_data,
  output word_t         o_rs2_data
);

  word_t regs [0:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd != '0)) begin
      // x0 is never written
      regs[i_rd] <= i_rd_data;
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // x0 reads zero on both ports
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((i_rs1 != '0) || (o_rs1_data == '0)) && ((i_rs2 != '0) || (o_rs2_data == '0)));

endmodule

`default_nettype wire

// File: hdl/instr_decode.sv
// combinational decoder that splits an instruction into fields, immediate, ALU operation and flags
`default_nettype none

module instr_decode
  import rv_pkg::*;
(
  input  wire instr_t i_instr,
  output reg_idx_t    o_rs1,
  output reg_idx_t    o_rs2,
  output reg_idx_t    o_rd,
  output word_t       o_imm,
  output alu_op_t     o_alu_op,
  output logic        o_use_imm,
  output logic        o_is_load,
  output logic        o_is_store,
  output logic        o_is_branch,
  output logic        o_branch_ne,
  output logic        o_writes_rd,
  output logic        o_illegal
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign o_rd   = i_instr[11:7];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];

  assign imm_i = {{52{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{52{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{51{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {{32{i_instr[31]}}, i_instr[31:12], 12'h000};

  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = ALU_ADD;
    o_use_imm   = 1'b0;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_is_branch = 1'b0;
    o_branch_ne = funct3[0];
    o_writes_rd = 1'b0;
    o_illegal   = 1'b0;
    case (opcode)
      OP_IMM: begin
        o_use_imm   = 1'b1;
        o_writes_rd = 1'b1;
        case (funct3)
          3'b000:  o_alu_op = ALU_ADD;
          3'b100:  o_alu_op = ALU_XOR;
          3'b110:  o_alu_op = ALU_OR;
          3'b111:  o_alu_op = ALU_AND;
          default: o_illegal = 1'b1;
        endcase
      end
      OP: begin
        o_writes_rd = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: o_alu_op = ALU_ADD;
          10'b0100000_000: o_alu_op = ALU_SUB;
          10'b0000000_111: o_alu_op = ALU_AND;
          10'b0000000_110: o_alu_op = ALU_OR;
          10'b0000000_100: o_alu_op = ALU_XOR;
          10'b0000000_001: o_alu_op = ALU_SLL;
          10'b0000000_101: o_alu_op = ALU_SRL;
          default:         o_illegal = 1'b1;
        endcase
      end
      LUI: begin
        o_imm       = imm_u;
        o_alu_op    = ALU_PASS_B;
        o_use_imm   = 1'b1;
        o_writes_rd = 1'b1;
      end
      LOAD: begin
        // address goes through the adder
        o_use_imm   = 1'b1;
        o_is_load   = 1'b1;
        o_writes_rd = 1'b1;
        o_illegal   = (funct3 != 3'b011);
      end
      STORE: begin
        o_imm      = imm_s;
        o_use_imm  = 1'b1;
        o_is_store = 1'b1;
        o_illegal  = (funct3 != 3'b011);
      end
      BRANCH: begin
        o_imm       = imm_b;
        o_alu_op    = ALU_EQ;
        o_is_branch = 1'b1;
        o_illegal   = (funct3[2:1] != 2'b00);
      end
      default: o_illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/alu.sv
// combinational 64-bit ALU for the core's add, logic, shift and compare operations
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  wire alu_op_t i_op,
  input  wire word_t   i_a,
  input  wire word_t   i_b,
  output word_t        o_result
);

  logic [5:0] shamt;

  // rv64 shifts use six bits
  assign shamt = i_b[5:0];

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_OR:     o_result = i_a | i_b;
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SLL:    o_result = i_a << shamt;
      ALU_SRL:    o_result = i_a >> shamt;
      ALU_PASS_B: o_result = i_b;
      ALU_EQ:     o_result = {63'd0, i_a == i_b};
      default:    o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/core_ctrl.sv
// core controller that holds the pc and instruction latch and sequences the Wishbone master
`default_nettype none

module core_ctrl
  import rv_pkg::*;
#(
  parameter addr_t RESET_PC = '0
) (
  input  wire           clk,
  input  wire           rst,
  output logic          o_wb_cyc,
  output logic          o_wb_stb,
  output logic          o_wb_we,
  output addr_t         o_wb_adr,
  output word_t         o_wb_dat,
  output logic [7:0]    o_wb_sel,
  input  wire word_t    i_wb_dat,
  input  wire           i_wb_ack,
  output instr_t        o_instr,
  input  wire reg_idx_t i_rd,
  input  wire word_t    i_imm,
  input  wire           i_use_imm,
  input  wire           i_is_load,
  input  wire           i_is_store,
  input  wire           i_is_branch,
  input  wire           i_branch_ne,
  input  wire           i_writes_rd,
  input  wire           i_illegal,
  input  wire word_t    i_rs1_data,
  input  wire word_t    i_rs2_data,
  output logic          o_rd_wen,
  output word_t         o_rd_data,
  output word_t         o_alu_a,
  output word_t         o_alu_b,
  input  wire word_t    i_alu_result,
  output logic          o_commit_valid,
  output addr_t         o_pc_commit,
  output logic          o_halt
);

  ctrl_state_t state;
  addr_t       pc;
  instr_t      instr_q;
  word_t       load_q;
  logic        is_mem;
  logic        taken;
  logic        misaligned;

  assign o_instr  = instr_q;
  assign o_wb_sel = '1;
  assign o_alu_a  = i_rs1_data;
  assign o_alu_b  = i_use_imm ? i_imm : i_rs2_data;

  assign is_mem     = i_is_load || i_is_store;
  // eq result sits in bit 0 and is inverted for bne
  assign taken      = i_alu_result[0] ^ i_branch_ne;
  assign misaligned = (i_alu_result[2:0] != 3'b000);

  assign o_rd_wen       = (state == ST_WRITEBACK) && i_writes_rd;
  assign o_rd_data      = i_is_load ? load_q : i_alu_result;
  assign o_commit_valid = o_rd_wen && (i_rd != '0);
  assign o_pc_commit    = pc;
  assign o_halt         = (state == ST_HALTED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_FETCH;
      pc       <= RESET_PC;
      o_wb_cyc <= 1'b0;
      o_wb_stb <= 1'b0;
      o_wb_we  <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (!o_wb_cyc) begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
            o_wb_we  <= 1'b0;
          end else if (i_wb_ack) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            state    <= ST_EXECUTE;
          end
        end
        ST_EXECUTE: begin
          if (i_illegal || (is_mem && misaligned)) begin
            state <= ST_HALTED;
          end else if (is_mem) begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
            o_wb_we  <= i_is_store;
            state    <= ST_MEM;
          end else if (i_is_branch) begin
            pc    <= taken ? pc + i_imm : pc + 64'd4;
            state <= ST_FETCH;
          end else begin
            state <= ST_WRITEBACK;
          end
        end
        ST_MEM: begin
          if (i_wb_ack) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
            if (i_is_store) begin
              pc    <= pc + 64'd4;
              state <= ST_FETCH;
            end else begin
              state <= ST_WRITEBACK;
            end
          end
        end
        ST_WRITEBACK: begin
          pc    <= pc + 64'd4;
          state <= ST_FETCH;
        end
        ST_HALTED: begin
          // idle until reset
          state <= ST_HALTED;
        end
        default: state <= ST_HALTED;
      endcase
    end
  end

  // bus address, store data and the two latches
  always_ff @(posedge clk) begin
    if ((state == ST_FETCH) && !o_wb_cyc) begin
      o_wb_adr <= {pc[63:3], 3'b000};
    end else if (state == ST_EXECUTE) begin
      o_wb_adr <= i_alu_result;
      o_wb_dat <= i_rs2_data;
    end
    if ((state == ST_FETCH) && o_wb_cyc && i_wb_ack) begin
      // upper word for pc[2] set
      instr_q <= pc[2] ? i_wb_dat[63:32] : i_wb_dat[31:0];
    end
    if ((state == ST_MEM) && i_wb_ack) begin
      load_q <= i_wb_dat;
    end
  end

  a_bus_hold: assert property (@(posedge clk) disable iff (rst)
    o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_we)
                              && $stable(o_wb_dat));

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
// rv64 core top level; connects controller, decoder, ALU and register file to one Wishbone port
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter addr_t RESET_PC = '0
) (
  input  wire        clk,
  input  wire        rst,
  output wire        o_wb_cyc,
  output wire        o_wb_stb,
  output wire        o_wb_we,
  output addr_t      o_wb_adr,
  output word_t      o_wb_dat,
  output wire [7:0]  o_wb_sel,
  input  wire word_t i_wb_dat,
  input  wire        i_wb_ack,
  output wire        o_commit_valid,
  output reg_idx_t   o_commit_rd,
  output word_t      o_commit_data,
  output addr_t      o_pc_commit,
  output wire        o_halt
);

  instr_t   instr;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_t  alu_op;
  logic     use_imm;
  logic     is_load;
  logic     is_store;
  logic     is_branch;
  logic     branch_ne;
  logic     writes_rd;
  logic     illegal;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     rd_wen;
  word_t    rd_data;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;

  // commit port mirrors the register write
  assign o_commit_rd   = rd;
  assign o_commit_data = rd_data;

  core_ctrl #(
    .RESET_PC(RESET_PC)
  ) core_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .o_wb_we       (o_wb_we),
    .o_wb_adr      (o_wb_adr),
    .o_wb_dat      (o_wb_dat),
    .o_wb_sel      (o_wb_sel),
    .i_wb_dat      (i_wb_dat),
    .i_wb_ack      (i_wb_ack),
    .o_instr       (instr),
    .i_rd          (rd),
    .i_imm         (imm),
    .i_use_imm     (use_imm),
    .i_is_load     (is_load),
    .i_is_store    (is_store),
    .i_is_branch   (is_branch),
    .i_branch_ne   (branch_ne),
    .i_writes_rd   (writes_rd),
    .i_illegal     (illegal),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .o_rd_wen      (rd_wen),
    .o_rd_data     (rd_data),
    .o_alu_a       (alu_a),
    .o_alu_b       (alu_b),
    .i_alu_result  (alu_result),
    .o_commit_valid(o_commit_valid),
    .o_pc_commit   (o_pc_commit),
    .o_halt        (o_halt)
  );

  instr_decode instr_decode_inst (
    .i_instr    (instr),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_alu_op   (alu_op),
    .o_use_imm  (use_imm),
    .o_is_load  (is_load),
    .o_is_store (is_store),
    .o_is_branch(is_branch),
    .o_branch_ne(branch_ne),
    .o_writes_rd(writes_rd),
    .o_illegal  (illegal)
  );

  alu alu_inst (
    .i_op    (alu_op),
    .i_a     (alu_a),
    .i_b     (alu_b),
    .o_result(alu_result)
  );

  regfile regfile_inst (
    .clk       (clk),
    .rst       (rst),
    .i_rs1     (rs1),
    .i_rs2     (rs2),
    .i_rd      (rd),
    .i_rd_wen  (rd_wen),
    .i_rd_data (rd_data),
    .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data)
  );

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
// self-checking testbench for rv_core with a Wishbone memory model, ISA reference model and scoreboard
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int EV_NONE   = 0;
  localparam int EV_COMMIT = 1;
  localparam int EV_STORE  = 2;
  localparam int EV_HALT   = 3;

  logic       clk;
  logic       rst;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  addr_t      wb_adr;
  word_t      wb_dat_w;
  logic [7:0] wb_sel;
  word_t      wb_dat_r;
  logic       wb_ack;
  logic       commit_valid;
  reg_idx_t   commit_rd;
  word_t      commit_data;
  addr_t      pc_commit;
  logic       halt;

  // bus-side memory and the reference model's own copy
  word_t    mem [0:63];
  word_t    m_mem [0:63];
  word_t    m_regs [0:31];
  addr_t    m_pc;
  addr_t    halt_pc;
  reg_idx_t exp_rd [$];
  word_t    exp_val [$];
  addr_t    exp_pc [$];
  addr_t    st_adr [$];
  word_t    st_dat [$];

  logic [31:0] lcg_state;
  bit          pending;
  int          wait_cnt;
  addr_t       req_adr;
  logic        req_we;
  word_t       req_dat;
  int          checks;
  int          value_errs;
  int          other_errs;
  bit          timed_out;

  rv_core #(
    .RESET_PC(64'h0)
  ) rv_core_inst (
    .clk           (clk),
    .rst           (rst),
    .o_wb_cyc      (wb_cyc),
    .o_wb_stb      (wb_stb),
    .o_wb_we       (wb_we),
    .o_wb_adr      (wb_adr),
    .o_wb_dat      (wb_dat_w),
    .o_wb_sel      (wb_sel),
    .i_wb_dat      (wb_dat_r),
    .i_wb_ack      (wb_ack),
    .o_commit_valid(commit_valid),
    .o_commit_rd   (commit_rd),
    .o_commit_data (commit_data),
    .o_pc_commit   (pc_commit),
    .o_halt        (halt)
  );

  always #50 clk = ~clk;

  function automatic int lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // memory slave with a random ack delay of 0 to 3 cycles
  always begin
    @(posedge clk);
    #10;
    if (rst || wb_ack) begin
      // request drops for a cycle after ack
      if (!rst && (wb_cyc || wb_stb)) begin
        other_errs++;
        $display("cyc or stb still high in the cycle after ack at %0t", $time);
      end
      wb_ack = 1'b0;
      pending = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!pending) begin
        pending = 1'b1;
        wait_cnt = lcg_next() % 4;
        req_adr = wb_adr;
        req_we = wb_we;
        req_dat = wb_dat_w;
        if (wb_sel !== 8'hff) begin
          other_errs++;
          $display("byte select not all ones at %0t", $time);
        end
      end else begin
        // request must hold while waiting
        check_addr("o_wb_adr", wb_adr, req_adr);
        if (wb_we !== req_we) begin
          other_errs++;
          $display("o_wb_we changed while waiting for ack at %0t", $time);
        end
        if (req_we) check_word("o_wb_dat", wb_dat_w, req_dat);
      end
      if (wait_cnt == 0) begin
        if (wb_we) mem[wb_adr[8:3]] = wb_dat_w;
        else wb_dat_r = mem[wb_adr[8:3]];
        wb_ack = 1'b1;
      end else begin
        wait_cnt--;
      end
    end else if (pending) begin
      other_errs++;
      pending = 1'b0;
      $display("bus request dropped before ack at %0t", $time);
    end
  end

  // scoreboard sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (wb_stb !== wb_cyc) begin
        other_errs++;
        $display("o_wb_stb and o_wb_cyc differ at %0t", $time);
      end
      if (halt && (wb_cyc || commit_valid)) begin
        other_errs++;
        $display("bus request or commit after halt at %0t", $time);
      end
      if (commit_valid) begin
        if (exp_rd.size() == 0) begin
          other_errs++;
          $display("unexpected commit to x%0d at %0t", commit_rd, $time);
        end else begin
          check_idx("o_commit_rd", commit_rd, exp_rd.pop_front());
          check_word("o_commit_data", commit_data, exp_val.pop_front());
          check_addr("o_pc_commit", pc_commit, exp_pc.pop_front());
        end
      end
      if (wb_cyc && wb_we && wb_ack) begin
        if (st_adr.size() == 0) begin
          other_errs++;
          $display("unexpected bus write to %h at %0t", wb_adr, $time);
        end else begin
          check_addr("o_wb_adr", wb_adr, st_adr.pop_front());
          check_word("o_wb_dat", wb_dat_w, st_dat.pop_front());
        end
      end
    end
  end

  // executes one instruction on the model state
  function automatic int ref_step(output reg_idx_t rd, output word_t val, output addr_t adr);
    instr_t     ins;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    addr_t      next_pc;
    int         kind;
    ins = m_pc[2] ? m_mem[m_pc[8:3]][63:32] : m_mem[m_pc[8:3]][31:0];
    f3 = ins[14:12];
    rd = ins[11:7];
    a = m_regs[ins[19:15]];
    b = m_regs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    val = '0;
    adr = '0;
    next_pc = m_pc + 64'd4;
    kind = EV_COMMIT;
    case (ins[6:0])
      OP_IMM: begin
        case (f3)
          3'b000: val = a + imm_i;
          3'b100: val = a ^ imm_i;
          3'b110: val = a | imm_i;
          3'b111: val = a & imm_i;
          default: kind = EV_HALT;
        endcase
      end
      OP: begin
        if (ins[31:25] == 7'h20 && f3 == 3'b000) begin
          val = a - b;
        end else if (ins[31:25] != 7'h00) begin
          kind = EV_HALT;
        end else begin
          case (f3)
            3'b000: val = a + b;
            3'b001: val = a << b[5:0];
            3'b100: val = a ^ b;
            3'b101: val = a >> b[5:0];
            3'b110: val = a | b;
            3'b111: val = a & b;
            default: kind = EV_HALT;
          endcase
        end
      end
      LUI: val = {{32{ins[31]}}, ins[31:12], 12'h000};
      LOAD: begin
        adr = a + imm_i;
        if (f3 != 3'b011 || adr[2:0] != 3'b000) kind = EV_HALT;
        else val = m_mem[adr[8:3]];
      end
      STORE: begin
        adr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
        val = b;
        kind = (f3 != 3'b011 || adr[2:0] != 3'b000) ? EV_HALT : EV_STORE;
      end
      BRANCH: begin
        kind = (f3[2:1] != 2'b00) ? EV_HALT : EV_NONE;
        if ((a == b) != f3[0]) begin
          next_pc = m_pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      default: kind = EV_HALT;
    endcase
    if (kind == EV_STORE) m_mem[adr[8:3]] = b;
    if (kind == EV_COMMIT) begin
      // x0 stays zero and is not reported
      if (rd == '0) kind = EV_NONE;
      else m_regs[rd] = val;
    end
    if (kind != EV_HALT) m_pc = next_pc;
    return kind;
  endfunction

  function automatic instr_t enc_i(opcode_t op, int rd, logic [2:0] f3, int rs1,
                                   logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), op};
  endfunction

  function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP};
  endfunction

  function automatic instr_t enc_s(int rs2, int rs1, logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b011, imm[4:0], STORE};
  endfunction

  function automatic instr_t enc_b(logic [2:0] f3, int rs1, int rs2, logic [12:0] off);
    return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], BRANCH};
  endfunction

  function automatic instr_t enc_u(int rd, logic [19:0] imm);
    return {imm, 5'(rd), LUI};
  endfunction

  task automatic load_program(input int which);
    instr_t prog [$];
    for (int i = 0; i < 64; i++) begin
      mem[i] = 64'hc3a5_0000_0000_0000 ^ (64'(i) * 64'h0102_0408_1020_4081);
    end
    if (which == 0) begin
      prog.push_back(enc_i(OP_IMM, 1, 3'b000, 0, 12'h123));
      prog.push_back(enc_i(OP_IMM, 2, 3'b000, 0, 12'hffb));
      prog.push_back(enc_i(OP_IMM, 3, 3'b100, 1, 12'h0ff));
      prog.push_back(enc_i(OP_IMM, 4, 3'b110, 2, 12'h070));
      prog.push_back(enc_i(OP_IMM, 5, 3'b111, 1, 12'h8f0));
      prog.push_back(enc_r(7'h00, 3'b000, 6, 1, 2));
      prog.push_back(enc_r(7'h20, 3'b000, 7, 1, 2));
      // shift amount 0x47 checks that only six bits count
      prog.push_back(enc_i(OP_IMM, 9, 3'b000, 0, 12'h047));
      prog.push_back(enc_r(7'h00, 3'b001, 8, 2, 9));
      prog.push_back(enc_r(7'h00, 3'b101, 10, 2, 9));
      prog.push_back(enc_u(11, 20'h80001));
      prog.push_back(enc_r(7'h00, 3'b111, 12, 11, 2));
      prog.push_back(enc_r(7'h00, 3'b110, 13, 11, 1));
      prog.push_back(enc_r(7'h00, 3'b100, 14, 11, 2));
      prog.push_back(enc_i(OP_IMM, 0, 3'b000, 1, 12'h005));
      prog.push_back(enc_r(7'h00, 3'b000, 15, 0, 1));
      prog.push_back(enc_i(OP_IMM, 16, 3'b000, 0, 12'h180));
      prog.push_back(enc_s(6, 16, 12'h000));
      prog.push_back(enc_s(11, 16, 12'h008));
      prog.push_back(enc_i(LOAD, 17, 3'b011, 16, 12'h000));
      prog.push_back(enc_i(LOAD, 18, 3'b011, 16, 12'h008));
      prog.push_back(enc_i(LOAD, 19, 3'b011, 16, 12'h010));
      prog.push_back(enc_b(3'b000, 17, 6, 13'h0008));
      prog.push_back(enc_i(OP_IMM, 20, 3'b000, 0, 12'h001));
      prog.push_back(enc_b(3'b001, 17, 6, 13'h0008));
      prog.push_back(enc_i(OP_IMM, 21, 3'b000, 0, 12'h002));
      // count down loop with a backward bne
      prog.push_back(enc_i(OP_IMM, 22, 3'b000, 0, 12'h003));
      prog.push_back(enc_i(OP_IMM, 22, 3'b000, 22, 12'hfff));
      prog.push_back(enc_b(3'b001, 22, 0, 13'h1ffc));
      prog.push_back(enc_b(3'b000, 1, 2, 13'h0008));
      prog.push_back(enc_i(OP_IMM, 23, 3'b000, 22, 12'h004));
      prog.push_back(32'h0000_006f);
    end else begin
      prog.push_back(enc_i(OP_IMM, 1, 3'b000, 0, 12'h184));
      prog.push_back(enc_s(1, 1, 12'hffc));
      prog.push_back(enc_i(LOAD, 2, 3'b011, 0, 12'h180));
      // misaligned doubleword load
      prog.push_back(enc_i(LOAD, 3, 3'b011, 1, 12'h000));
      prog.push_back(enc_i(OP_IMM, 4, 3'b000, 0, 12'h001));
    end
    for (int k = 0; k < prog.size(); k++) begin
      if (k % 2 == 1) mem[k / 2][63:32] = prog[k];
      else mem[k / 2][31:0] = prog[k];
    end
    m_mem = mem;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_pc = '0;
  endtask

  task automatic build_expected(output int steps);
    reg_idx_t rd;
    word_t    val;
    addr_t    adr;
    addr_t    pc;
    int       kind;
    exp_rd.delete();
    exp_val.delete();
    exp_pc.delete();
    st_adr.delete();
    st_dat.delete();
    steps = 0;
    kind = EV_NONE;
    while (kind != EV_HALT && steps < 400) begin
      pc = m_pc;
      kind = ref_step(rd, val, adr);
      steps++;
      if (kind == EV_COMMIT) begin
        exp_rd.push_back(rd);
        exp_val.push_back(val);
        exp_pc.push_back(pc);
      end else if (kind == EV_STORE) begin
        st_adr.push_back(adr);
        st_dat.push_back(val);
      end
    end
    halt_pc = m_pc;
  endtask

  task automatic run_program(input int which, output bit to);
    int n;
    int limit;
    int steps;
    load_program(which);
    build_expected(steps);
    limit = steps * 4 * 8 + 40;
    @(posedge clk);
    #10;
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    n = 0;
    while (!halt && n < limit) begin
      @(negedge clk);
      n++;
    end
    to = !halt;
    if (to) begin
      $display("timeout: program %0d did not halt within %0d cycles, state %s",
               which, limit, rv_core_inst.core_ctrl_inst.state.name());
    end else begin
      check_addr("o_pc_commit at halt", pc_commit, halt_pc);
      // stay quiet after halt
      repeat (8) @(negedge clk);
      if (exp_rd.size() != 0 || st_adr.size() != 0) begin
        other_errs++;
        $display("program %0d halted with %0d commits and %0d stores still expected",
                 which, exp_rd.size(), st_adr.size());
      end
    end
  endtask

  task automatic finish_run(input bit to);
    $display("checks %0d, value errors %0d, other errors %0d, timeouts %0d",
             checks, value_errs, other_errs, to);
    if (to || value_errs != 0 || other_errs != 0) begin
      $display("** FAIL **");
    end else begin
      $display("** PASS **");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wb_ack = 1'b0;
    wb_dat_r = '0;
    lcg_state = 32'd86434;
    pending = 1'b0;
    wait_cnt = 0;
    checks = 0;
    value_errs = 0;
    other_errs = 0;
    timed_out = 1'b0;
    run_program(0, timed_out);
    if (!timed_out) run_program(1, timed_out);
    finish_run(timed_out);
  end

endmodule

`default_nettype wire

// File: files.f
hdl/rv_pkg.sv
hdl/regfile.sv
hdl/instr_decode.sv
hdl/alu.sv
hdl/core_ctrl.sv
hdl/rv_core.sv
tb/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
